// ==== build.f ====
src/vlsu_pkg.sv
src/vlsu_addrgen.sv
src/vlsu_load_unit.sv
src/vlsu_store_unit.sv
src/vlsu_mem_arb.sv
src/vlsu_top.sv
sim/vlsu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module vlsu_tb -Mdir obj_dir

out=$(./obj_dir/Vvlsu_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1

// ==== sim/vlsu_input.txt ====
# kind name base stride vl then vl hex words (S operands to store, L expected load data)
# every store is followed directly by a load, so loads also wait on the store queue
S unit_store 0000 0004 8 11110000 22220001 33330002 44440003 55550004 66660005 77770006 88880007
L unit_load 0000 0004 8 11110000 22220001 33330002 44440003 55550004 66660005 77770006 88880007
S stride8_store 0100 0008 4 a0a00001 b0b00002 c0c00003 d0d00004
L stride8_load 0100 0008 4 a0a00001 b0b00002 c0c00003 d0d00004
L stride8_gap 0104 0008 4 00000000 00000000 00000000 00000000
S negstride_store 0220 fffc 3 0badf00d 12345678 deadbeef
L negstride_load 0218 0004 3 deadbeef 12345678 0badf00d
S zero_store 0300 0004 0
L zero_load 0300 0004 0
S random_store 0280 0004 8 00000101 00000202 00000303 00000404 00000505 00000606 00000707 00000808
L random_load 0280 0004 8 00000101 00000202 00000303 00000404 00000505 00000606 00000707 00000808
S single_store 03fc fffc 1 cafef00d
L single_load 03fc 0004 1 cafef00d

// ==== sim/vlsu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vlsu_tb;

  localparam int unsigned MemWords = 256;
  localparam int unsigned Timeout  = 200;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 insn_valid;
  logic                 insn_store;
  vlsu_pkg::addr_t      insn_base;
  vlsu_pkg::stride_t    insn_stride;
  vlsu_pkg::vl_t        insn_vl;
  logic                 insn_ready;
  logic                 load_complete;
  logic                 store_complete;
  logic                 store_pending;
  logic                 st_operand_valid;
  vlsu_pkg::elem_t      st_operand;
  logic                 ld_result_valid;
  vlsu_pkg::elem_idx_t  ld_result_idx;
  vlsu_pkg::elem_t      ld_result_data;
  logic                 mem_req;
  logic                 mem_we;
  vlsu_pkg::word_addr_t mem_addr;
  vlsu_pkg::elem_t      mem_wdata;
  logic                 mem_rvalid = 1'b0;
  vlsu_pkg::elem_t      mem_rdata = '0;

  vlsu_pkg::elem_t      mem [MemWords];
  vlsu_pkg::elem_t      exp_mem [MemWords];
  vlsu_pkg::word_addr_t wr_log_addr [$];
  vlsu_pkg::elem_t      wr_log_data [$];
  vlsu_pkg::word_addr_t exp_wr_addr [$];
  vlsu_pkg::elem_t      exp_wr_data [$];
  int unsigned          mem_access_cnt = 0;
  int unsigned          st_cmp_cnt = 0;
  int unsigned          ld_cmp_cnt = 0;
  int unsigned          stores_done = 0;
  logic [31:0]          rng_state = 32'hde92_4de3;

  always #2 clk = ~clk;

  vlsu_top dut_i (
    .clk_i             (clk             ),
    .rst_n_i           (rst_n           ),
    .insn_valid_i      (insn_valid      ),
    .insn_store_i      (insn_store      ),
    .insn_base_i       (insn_base       ),
    .insn_stride_i     (insn_stride     ),
    .insn_vl_i         (insn_vl         ),
    .insn_ready_o      (insn_ready      ),
    .load_complete_o   (load_complete   ),
    .store_complete_o  (store_complete  ),
    .store_pending_o   (store_pending   ),
    .st_operand_valid_i(st_operand_valid),
    .st_operand_i      (st_operand      ),
    .ld_result_valid_o (ld_result_valid ),
    .ld_result_idx_o   (ld_result_idx   ),
    .ld_result_data_o  (ld_result_data  ),
    .mem_req_o         (mem_req         ),
    .mem_we_o          (mem_we          ),
    .mem_addr_o        (mem_addr        ),
    .mem_wdata_o       (mem_wdata       ),
    .mem_rvalid_i      (mem_rvalid      ),
    .mem_rdata_i       (mem_rdata       )
  );

  ////////////////////////////////////////
  // Memory model with one cycle read latency
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < MemWords; w++) begin
        mem[w] <= '0;
      end
      mem_rvalid <= 1'b0;
      mem_rdata  <= '0;
    end else begin
      mem_rvalid <= mem_req && !mem_we;
      mem_rdata  <= mem[mem_addr[7:0]];
      if (mem_req && mem_we) begin
        mem[mem_addr[7:0]] <= mem_wdata;
        wr_log_addr.push_back(mem_addr);
        wr_log_data.push_back(mem_wdata);
      end
      if (mem_req) begin
        mem_access_cnt++;
      end
    end
  end

  // Completion pulses counted in the middle of the cycle
  always @(negedge clk) begin
    if (rst_n && store_complete) st_cmp_cnt++;
    if (rst_n && load_complete) ld_cmp_cnt++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: test %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      report_failure("Mismatch detected");
    end
  endtask

  ////////////////////////////////////////
  // Instruction issue and checking
  ////////////////////////////////////////

  task automatic issue_insn(input string name, input logic store, input vlsu_pkg::addr_t base,
                            input vlsu_pkg::stride_t stride, input vlsu_pkg::vl_t vl);
    int unsigned waited;
    @(posedge clk);
    #1;
    insn_valid  = 1'b1;
    insn_store  = store;
    insn_base   = base;
    insn_stride = stride;
    insn_vl     = vl;
    waited      = 0;
    @(negedge clk);
    while (!insn_ready) begin
      waited++;
      if (waited > Timeout) begin
        report_failure($sformatf("Timeout: instruction %s was never accepted", name));
      end
      @(negedge clk);
    end
    // A load may only start once every earlier store has reached memory
    if (!store) begin
      check_value(name, "store_pending at load issue", 0, store_pending);
      check_value(name, "writes done before load", exp_wr_addr.size(), wr_log_addr.size());
    end
    @(posedge clk);
    #1;
    insn_valid = 1'b0;
  endtask

  task automatic send_operands(input vlsu_pkg::addr_t base, input vlsu_pkg::stride_t stride,
                               input vlsu_pkg::vl_t vl, input vlsu_pkg::elem_t ops [8]);
    int unsigned     sent;
    int unsigned     issued;
    vlsu_pkg::addr_t a;
    sent = 0;
    // Cycle k after acceptance has issued min(k, vl) addresses
    for (int k = 1; sent < vl; k++) begin
      issued    = (k < vl) ? k : vl;
      rng_state = xorshift32(rng_state);
      if (issued > sent && (rng_state[0] || issued - sent >= 2)) begin
        st_operand_valid = 1'b1;
        st_operand       = ops[sent];
        a = base + vlsu_pkg::addr_t'(sent) * vlsu_pkg::addr_t'(stride);
        exp_wr_addr.push_back(a[15:2]);
        exp_wr_data.push_back(ops[sent]);
        exp_mem[a[9:2]] = ops[sent];
        sent++;
      end else begin
        st_operand_valid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    st_operand_valid = 1'b0;
  endtask

  task automatic collect_results(input string name, input vlsu_pkg::vl_t vl,
                                 input vlsu_pkg::elem_t exp_data [8]);
    int unsigned n;
    int unsigned got;
    n   = 0;
    got = 0;
    while (got < vl) begin
      @(negedge clk);
      n++;
      if (n > Timeout) begin
        report_failure($sformatf("Timeout: load %s returned too few results", name));
      end
      if (ld_result_valid) begin
        check_value(name, "result index", got, ld_result_idx);
        check_value(name, "result cycle", got + 3, n);
        check_value(name, "result data", exp_data[got], ld_result_data);
        check_value(name, "load_complete", got == vl - 1, load_complete);
        got++;
      end else begin
        check_value(name, "load_complete without result", 0, load_complete);
      end
    end
    @(negedge clk);
    check_value(name, "extra result", 0, ld_result_valid);
  endtask

  task automatic check_idle_after_zero(input string name);
    int unsigned acc;
    int unsigned lc;
    int unsigned sc;
    acc = mem_access_cnt;
    lc  = ld_cmp_cnt;
    sc  = st_cmp_cnt;
    @(negedge clk);
    check_value(name, "insn_ready after zero length", 1, insn_ready);
    repeat (4) begin
      check_value(name, "result after zero length", 0, ld_result_valid);
      @(negedge clk);
    end
    check_value(name, "memory accesses", acc, mem_access_cnt);
    check_value(name, "load completions", lc, ld_cmp_cnt);
    check_value(name, "store completions", sc, st_cmp_cnt);
  endtask

  task automatic verify_writes(input string name);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (store_pending) begin
      waited++;
      if (waited > Timeout) begin
        report_failure($sformatf("Timeout: stores before %s never drained", name));
      end
      @(negedge clk);
    end
    @(negedge clk);
    check_value(name, "write count", exp_wr_addr.size(), wr_log_addr.size());
    foreach (exp_wr_addr[i]) begin
      check_value(name, $sformatf("write %0d address", i), exp_wr_addr[i], wr_log_addr[i]);
      check_value(name, $sformatf("write %0d data", i), exp_wr_data[i], wr_log_data[i]);
    end
    check_value(name, "store_complete pulses", stores_done, st_cmp_cnt);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int                   fd;
    int                   code;
    logic [8*8-1:0]       kind;
    logic [8*24-1:0]      name_vec;
    logic [8*160-1:0]     skip_line;
    string                name;
    vlsu_pkg::addr_t      base;
    vlsu_pkg::stride_t    stride;
    int unsigned          vl;
    vlsu_pkg::elem_t      words [8];

    rst_n            = 1'b0;
    insn_valid       = 1'b0;
    insn_store       = 1'b0;
    insn_base        = '0;
    insn_stride      = '0;
    insn_vl          = '0;
    st_operand_valid = 1'b0;
    st_operand       = '0;
    for (int w = 0; w < MemWords; w++) begin
      exp_mem[w] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("sim/vlsu_input.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open sim/vlsu_input.txt");
    end
    while (1) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) break;
      if (kind == "#") begin
        code = $fgets(skip_line, fd);
      end else begin
        code = $fscanf(fd, "%s %h %h %d", name_vec, base, stride, vl);
        name = $sformatf("%0s", name_vec);
        if (code != 4 || vl > vlsu_pkg::MaxVl) begin
          report_failure($sformatf("Malformed record %s in input file", name));
        end
        for (int i = 0; i < vl; i++) begin
          code = $fscanf(fd, "%h", words[i]);
        end
        issue_insn(name, kind == "S", base, stride, vlsu_pkg::vl_t'(vl));
        if (vl == 0) begin
          check_idle_after_zero(name);
        end else if (kind == "S") begin
          stores_done++;
          send_operands(base, stride, vlsu_pkg::vl_t'(vl), words);
        end else begin
          collect_results(name, vlsu_pkg::vl_t'(vl), words);
          verify_writes(name);
        end
      end
    end
    $fclose(fd);

    verify_writes("final");
    for (int w = 0; w < MemWords; w++) begin
      check_value("final", $sformatf("memory word %0d", w), exp_mem[w], mem[w]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/vlsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vlsu_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Core side
  input  logic                 insn_valid_i,
  input  logic                 insn_store_i,
  input  vlsu_pkg::addr_t      insn_base_i,
  input  vlsu_pkg::stride_t    insn_stride_i,
  input  vlsu_pkg::vl_t        insn_vl_i,
  output logic                 insn_ready_o,
  output logic                 load_complete_o,
  output logic                 store_complete_o,
  output logic                 store_pending_o,
  // Lanes side
  input  logic                 st_operand_valid_i,
  input  vlsu_pkg::elem_t      st_operand_i,
  output logic                 ld_result_valid_o,
  output vlsu_pkg::elem_idx_t  ld_result_idx_o,
  output vlsu_pkg::elem_t      ld_result_data_o,
  // Memory port
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output vlsu_pkg::word_addr_t mem_addr_o,
  output vlsu_pkg::elem_t      mem_wdata_o,
  input  logic                 mem_rvalid_i,
  input  vlsu_pkg::elem_t      mem_rdata_i
);

  logic                ld_addr_valid;
  logic                st_addr_valid;
  vlsu_pkg::addr_t     elem_addr;
  vlsu_pkg::elem_idx_t elem_idx;
  logic                elem_last;
  logic                rd_req;
  vlsu_pkg::addr_t     rd_addr;
  logic                rvalid;
  vlsu_pkg::elem_t     rdata;
  logic                wr_req;
  vlsu_pkg::addr_t     wr_addr;
  vlsu_pkg::elem_t     wr_data;
  logic                wr_gnt;

  ////////////////////////////////////////
  // Address generation
  ////////////////////////////////////////

  vlsu_addrgen i_addrgen (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .insn_valid_i   (insn_valid_i   ),
    .insn_store_i   (insn_store_i   ),
    .insn_base_i    (insn_base_i    ),
    .insn_stride_i  (insn_stride_i  ),
    .insn_vl_i      (insn_vl_i      ),
    .store_pending_i(store_pending_o),
    .insn_ready_o   (insn_ready_o   ),
    .ld_addr_valid_o(ld_addr_valid  ),
    .st_addr_valid_o(st_addr_valid  ),
    .elem_addr_o    (elem_addr      ),
    .elem_idx_o     (elem_idx       ),
    .elem_last_o    (elem_last      )
  );

  ////////////////////////////////////////
  // Load and store units
  ////////////////////////////////////////

  vlsu_load_unit i_load_unit (
    .clk_i          (clk_i            ),
    .rst_n_i        (rst_n_i          ),
    .addr_valid_i   (ld_addr_valid    ),
    .addr_i         (elem_addr        ),
    .idx_i          (elem_idx         ),
    .last_i         (elem_last        ),
    .rvalid_i       (rvalid           ),
    .rdata_i        (rdata            ),
    .rd_req_o       (rd_req           ),
    .rd_addr_o      (rd_addr          ),
    .result_valid_o (ld_result_valid_o),
    .result_idx_o   (ld_result_idx_o  ),
    .result_data_o  (ld_result_data_o ),
    .load_complete_o(load_complete_o  )
  );

  vlsu_store_unit i_store_unit (
    .clk_i           (clk_i             ),
    .rst_n_i         (rst_n_i           ),
    .addr_valid_i    (st_addr_valid     ),
    .addr_i          (elem_addr         ),
    .last_i          (elem_last         ),
    .operand_valid_i (st_operand_valid_i),
    .operand_i       (st_operand_i      ),
    .wr_gnt_i        (wr_gnt            ),
    .wr_req_o        (wr_req            ),
    .wr_addr_o       (wr_addr           ),
    .wr_data_o       (wr_data           ),
    .store_pending_o (store_pending_o   ),
    .store_complete_o(store_complete_o  )
  );

  ////////////////////////////////////////
  // Memory port
  ////////////////////////////////////////

  vlsu_mem_arb i_mem_arb (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .rd_req_i    (rd_req      ),
    .rd_addr_i   (rd_addr     ),
    .wr_req_i    (wr_req      ),
    .wr_addr_i   (wr_addr     ),
    .wr_data_i   (wr_data     ),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i (mem_rdata_i ),
    .wr_gnt_o    (wr_gnt      ),
    .rvalid_o    (rvalid      ),
    .rdata_o     (rdata       ),
    .mem_req_o   (mem_req_o   ),
    .mem_we_o    (mem_we_o    ),
    .mem_addr_o  (mem_addr_o  ),
    .mem_wdata_o (mem_wdata_o )
  );

endmodule

`default_nettype wire

// ==== src/vlsu_mem_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vlsu_mem_arb (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 rd_req_i,
  input  vlsu_pkg::addr_t      rd_addr_i,
  input  logic                 wr_req_i,
  input  vlsu_pkg::addr_t      wr_addr_i,
  input  vlsu_pkg::elem_t      wr_data_i,
  input  logic                 mem_rvalid_i,
  input  vlsu_pkg::elem_t      mem_rdata_i,
  output logic                 wr_gnt_o,
  output logic                 rvalid_o,
  output vlsu_pkg::elem_t      rdata_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output vlsu_pkg::word_addr_t mem_addr_o,
  output vlsu_pkg::elem_t      mem_wdata_o
);

  logic rd_outstanding_q;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Loads cannot stall, so the store yields
  assign wr_gnt_o  = wr_req_i && !rd_req_i;
  assign mem_req_o = rd_req_i || wr_req_i;
  assign mem_we_o  = wr_gnt_o;

  // Byte to word address
  assign mem_addr_o  = rd_req_i ? rd_addr_i[vlsu_pkg::AddrWidth-1:2]
                                : wr_addr_i[vlsu_pkg::AddrWidth-1:2];
  assign mem_wdata_o = wr_data_i;

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_outstanding_q <= 1'b0;
    end else begin
      rd_outstanding_q <= rd_req_i;
    end
  end

  assign rvalid_o = mem_rvalid_i && rd_outstanding_q;
  assign rdata_o  = mem_rdata_i;

  a_expected_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_i |-> rd_outstanding_q);

endmodule

`default_nettype wire

// ==== src/vlsu_store_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module vlsu_store_unit (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            addr_valid_i,
  input  vlsu_pkg::addr_t addr_i,
  input  logic            last_i,
  input  logic            operand_valid_i,
  input  vlsu_pkg::elem_t operand_i,
  input  logic            wr_gnt_i,
  output logic            wr_req_o,
  output vlsu_pkg::addr_t wr_addr_o,
  output vlsu_pkg::elem_t wr_data_o,
  output logic            store_pending_o,
  output logic            store_complete_o
);

  vlsu_pkg::addr_t   addr_mem_q [vlsu_pkg::StoreQueueDepth];
  logic              last_mem_q [vlsu_pkg::StoreQueueDepth];
  vlsu_pkg::elem_t   op_mem_q   [vlsu_pkg::StoreQueueDepth];

  vlsu_pkg::sq_ptr_t addr_wr_ptr_q;
  vlsu_pkg::sq_ptr_t addr_rd_ptr_q;
  vlsu_pkg::sq_ptr_t op_wr_ptr_q;
  vlsu_pkg::sq_ptr_t op_rd_ptr_q;
  vlsu_pkg::sq_cnt_t addr_cnt_q;
  vlsu_pkg::sq_cnt_t op_cnt_q;

  logic addr_full;
  logic op_full;
  logic pop;

  assign addr_full = addr_cnt_q == vlsu_pkg::sq_cnt_t'(vlsu_pkg::StoreQueueDepth);
  assign op_full   = op_cnt_q == vlsu_pkg::sq_cnt_t'(vlsu_pkg::StoreQueueDepth);

  // Head pair is offered once both halves are present
  assign wr_req_o  = (addr_cnt_q != '0) && (op_cnt_q != '0);
  assign wr_addr_o = addr_mem_q[addr_rd_ptr_q];
  assign wr_data_o = op_mem_q[op_rd_ptr_q];
  assign pop       = wr_req_o && wr_gnt_i;

  assign store_pending_o = (addr_cnt_q != '0) || (op_cnt_q != '0);

  ////////////////////////////////////////
  // Queue storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (addr_valid_i) begin
      addr_mem_q[addr_wr_ptr_q] <= addr_i;
      last_mem_q[addr_wr_ptr_q] <= last_i;
    end
    if (operand_valid_i) begin
      op_mem_q[op_wr_ptr_q] <= operand_i;
    end
  end

  ////////////////////////////////////////
  // Pointers and counts
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      addr_wr_ptr_q    <= '0;
      addr_rd_ptr_q    <= '0;
      op_wr_ptr_q      <= '0;
      op_rd_ptr_q      <= '0;
      addr_cnt_q       <= '0;
      op_cnt_q         <= '0;
      store_complete_o <= 1'b0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (addr_valid_i) addr_wr_ptr_q <= addr_wr_ptr_q + vlsu_pkg::sq_ptr_t'(1);
      if (operand_valid_i) op_wr_ptr_q <= op_wr_ptr_q + vlsu_pkg::sq_ptr_t'(1);
      if (pop) begin
        addr_rd_ptr_q <= addr_rd_ptr_q + vlsu_pkg::sq_ptr_t'(1);
        op_rd_ptr_q   <= op_rd_ptr_q + vlsu_pkg::sq_ptr_t'(1);
      end
      addr_cnt_q <= addr_cnt_q + vlsu_pkg::sq_cnt_t'(addr_valid_i)
                    - vlsu_pkg::sq_cnt_t'(pop);
      op_cnt_q   <= op_cnt_q + vlsu_pkg::sq_cnt_t'(operand_valid_i)
                    - vlsu_pkg::sq_cnt_t'(pop);
      // One cycle after the final write of the instruction
      store_complete_o <= pop && last_mem_q[addr_rd_ptr_q];
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((addr_valid_i && addr_full) || (operand_valid_i && op_full)) |-> pop);

  a_operand_has_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    operand_valid_i |-> (addr_cnt_q > op_cnt_q) || addr_valid_i);

endmodule

`default_nettype wire

// ==== src/vlsu_load_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module vlsu_load_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                addr_valid_i,
  input  vlsu_pkg::addr_t     addr_i,
  input  vlsu_pkg::elem_idx_t idx_i,
  input  logic                last_i,
  input  logic                rvalid_i,
  input  vlsu_pkg::elem_t     rdata_i,
  output logic                rd_req_o,
  output vlsu_pkg::addr_t     rd_addr_o,
  output logic                result_valid_o,
  output vlsu_pkg::elem_idx_t result_idx_o,
  output vlsu_pkg::elem_t     result_data_o,
  output logic                load_complete_o
);

  vlsu_pkg::elem_idx_t idx_q;
  logic                last_q;

  // Reads always win the port, so the address goes straight out
  assign rd_req_o  = addr_valid_i;
  assign rd_addr_o = addr_i;

  ////////////////////////////////////////
  // Tag pipeline
  ////////////////////////////////////////

  // Index follows the read through the memory latency
  always_ff @(posedge clk_i) begin
    if (addr_valid_i) begin
      idx_q <= idx_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= 1'b0;
    end else begin
      last_q <= addr_valid_i && last_i;
    end
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_valid_o  <= 1'b0;
      load_complete_o <= 1'b0;
    end else begin
      result_valid_o  <= rvalid_i;
      load_complete_o <= rvalid_i && last_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      result_idx_o  <= idx_q;
      result_data_o <= rdata_i;
    end
  end

  a_rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> $past(rd_req_o));

endmodule

`default_nettype wire

// ==== src/vlsu_addrgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module vlsu_addrgen (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                insn_valid_i,
  input  logic                insn_store_i,
  input  vlsu_pkg::addr_t     insn_base_i,
  input  vlsu_pkg::stride_t   insn_stride_i,
  input  vlsu_pkg::vl_t       insn_vl_i,
  input  logic                store_pending_i,
  output logic                insn_ready_o,
  output logic                ld_addr_valid_o,
  output logic                st_addr_valid_o,
  output vlsu_pkg::addr_t     elem_addr_o,
  output vlsu_pkg::elem_idx_t elem_idx_o,
  output logic                elem_last_o
);

  vlsu_pkg::addrgen_state_e state_q;
  vlsu_pkg::addr_t          addr_q;
  vlsu_pkg::stride_t        stride_q;
  vlsu_pkg::vl_t            remain_q;
  vlsu_pkg::elem_idx_t      idx_q;
  logic                     insn_accept;
  logic                     gen_active;

  // Loads wait for queued stores to drain while stores may follow each other
  assign insn_ready_o = (state_q == vlsu_pkg::idle) && (insn_store_i || !store_pending_i);
  assign insn_accept  = insn_valid_i && insn_ready_o;
  assign gen_active   = state_q != vlsu_pkg::idle;

  assign ld_addr_valid_o = state_q == vlsu_pkg::gen_load;
  assign st_addr_valid_o = state_q == vlsu_pkg::gen_store;
  assign elem_addr_o     = addr_q;
  assign elem_idx_o      = idx_q;
  assign elem_last_o     = gen_active && (remain_q == vlsu_pkg::vl_t'(1));

  ////////////////////////////////////////
  // Instruction FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= vlsu_pkg::idle;
      remain_q <= '0;
    end else begin
      case (state_q)
        vlsu_pkg::idle: begin
          // Zero length is taken but never leaves idle
          if (insn_accept && insn_vl_i != '0) begin
            state_q  <= insn_store_i ? vlsu_pkg::gen_store : vlsu_pkg::gen_load;
            remain_q <= insn_vl_i;
          end
        end
        default: begin
          remain_q <= remain_q - vlsu_pkg::vl_t'(1);
          if (elem_last_o) begin
            state_q <= vlsu_pkg::idle;
          end
        end
      endcase
    end
  end

  // Running address and element index
  always_ff @(posedge clk_i) begin
    if (insn_accept) begin
      addr_q   <= insn_base_i;
      stride_q <= insn_stride_i;
      idx_q    <= '0;
    end else if (gen_active) begin
      addr_q <= addr_q + vlsu_pkg::addr_t'(stride_q);
      idx_q  <= idx_q + vlsu_pkg::elem_idx_t'(1);
    end
  end

  a_one_unit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ld_addr_valid_o && st_addr_valid_o));

endmodule

`default_nettype wire

// ==== src/vlsu_pkg.sv ====
`default_nettype none

package vlsu_pkg;

  // Data and address widths
  localparam int unsigned ElemWidth     = 32;
  localparam int unsigned AddrWidth     = 16;
  localparam int unsigned WordAddrWidth = AddrWidth - 2;

  // Longest vector handled by one instruction
  localparam int unsigned MaxVl = 8;

  // Store address and operand queues
  localparam int unsigned StoreQueueDepth    = 4;
  localparam int unsigned StoreQueuePtrWidth = $clog2(StoreQueueDepth);

  typedef logic [ElemWidth-1:0]             elem_t;
  typedef logic [AddrWidth-1:0]             addr_t;
  typedef logic [WordAddrWidth-1:0]         word_addr_t;
  typedef logic signed [AddrWidth-1:0]      stride_t;
  typedef logic [$clog2(MaxVl+1)-1:0]       vl_t;
  typedef logic [$clog2(MaxVl)-1:0]         elem_idx_t;
  typedef logic [StoreQueuePtrWidth-1:0]    sq_ptr_t;
  typedef logic [StoreQueuePtrWidth:0]      sq_cnt_t;

  typedef enum logic [1:0] {
    idle,
    gen_load,
    gen_store
  } addrgen_state_e;

endpackage

`default_nettype wire
